/* common/game_mem_config.svh */
// Memory map and width settings for the game memory core, included by every RTL file that needs them
`ifndef GAME_MEM_CONFIG_SVH
`define GAME_MEM_CONFIG_SVH

// SDRAM word address width
`define SDRAM_AW    22
`define NUM_SLOTS   4

// Requester address widths
`define ROM_AW      21
`define RAM_AW      17
`define GFX_AW      20          // Half bit not included
`define SND_AW      16          // Byte address

// Word offsets inside bank 1
`define RAM_OFFSET  22'h200000
`define VRAM_OFFSET 22'h300000

// Byte addresses where each part of the loader stream begins
`define SND_START   25'h080000
`define GFX_START   25'h0C0000

// SDRAM bank of each region
`define BANK_CPU    2'd1
`define BANK_GFX    2'd2
`define BANK_SND    2'd0

`endif

/* common/game_mem_pkg.sv */
// Shared types for the slot requests, SDRAM commands and download writes; use by scoped name
`include "game_mem_config.svh"

package game_mem_pkg;

    // One requester as seen by the arbiter, address has no region offset yet
    typedef struct packed {
        logic                 valid;
        logic [`SDRAM_AW-1:0] addr;
        logic                 wr;
        logic [15:0]          wdata;
        logic [1:0]           wrmask;   // Active low
    } slot_req_t;

    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        logic [1:0]           bank;
        logic                 rnw;
        logic [15:0]          wdata;
        logic [1:0]           wrmask;
    } sdram_cmd_t;

    // Loader byte turned into an SDRAM programming write
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        logic [7:0]           data;
        logic [1:0]           mask;
        logic [1:0]           bank;
    } prog_wr_t;

    // Lower index has higher priority
    typedef enum logic [1:0] {
        SLOT_ROM = 2'd0,
        SLOT_RAM = 2'd1,
        SLOT_GFX = 2'd2,
        SLOT_SND = 2'd3
    } slot_id_e;

endpackage

/* sdram_mux/mem_slot.sv */
// One SDRAM requester: latches an access, caches the last read and returns ok and data
`include "game_mem_config.svh"

module mem_slot #(
    parameter int  AW     = 16,
    parameter type data_t = logic [15:0]
) (
    input  logic                   VB,
    input  logic                   rst_n,
    input  logic                   cs,
    input  logic [AW-1:0]          addr,
    input  logic                   wr,
    input  logic [15:0]            din,
    input  logic [1:0]             wrmask,
    output game_mem_pkg::slot_req_t req,
    input  logic                   grant,
    input  logic                   done,
    input  logic [31:0]            rdata,
    output logic                   ok,
    output data_t                  dout
);
    localparam int SAW = `SDRAM_AW;
    localparam int DW  = $bits(data_t);

    logic          cs_q;
    logic          valid;
    logic          valid_n;
    logic          served;         // Latched access has completed
    logic          served_n;
    logic          tag_valid;
    logic          tag_valid_n;
    logic          ok_q;
    logic [AW-1:0] acc_addr;
    logic          acc_wr;
    logic [15:0]   acc_din;
    logic [1:0]    acc_mask;
    logic [AW-1:0] tag_addr;
    data_t         tag_data;
    logic [31:0]   rsel;
    logic          cur_same;
    logic          hit;
    logic          new_acc;

    assign cur_same = (addr == acc_addr) && (wr == acc_wr);
    assign hit      = !wr && tag_valid && (addr == tag_addr);
    assign new_acc  = cs && (!cs_q || !cur_same) && !grant;   // Never relatch under a grant

    // Byte slots pick the upper half for odd addresses
    assign rsel = (DW == 8 && acc_addr[0]) ? (rdata >> 8) : rdata;

    always_comb begin
        valid_n     = valid;
        served_n    = served;
        tag_valid_n = tag_valid;
        if (done) begin
            valid_n  = 1'b0;
            served_n = 1'b1;
            if (!acc_wr)
                tag_valid_n = 1'b1;
        end
        if (!cs && !grant)
            valid_n = 1'b0;                 // Requester left before the arbiter took it
        if (new_acc) begin
            served_n = hit;
            valid_n  = !hit;
            if (wr)
                tag_valid_n = 1'b0;
        end
    end

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            cs_q      <= 1'b0;
            valid     <= 1'b0;
            served    <= 1'b0;
            tag_valid <= 1'b0;
            ok_q      <= 1'b0;
        end else begin
            cs_q      <= cs;
            valid     <= valid_n;
            served    <= served_n;
            tag_valid <= tag_valid_n;
            ok_q      <= cs && served_n && (new_acc || cur_same);
        end
    end

    always_ff @(posedge VB) begin
        if (new_acc) begin
            acc_addr <= addr;
            acc_wr   <= wr;
            acc_din  <= din;
            acc_mask <= wrmask;
        end
        if (done && !acc_wr) begin
            tag_addr <= acc_addr;
            tag_data <= rsel[DW-1:0];
        end
    end

    assign req.valid  = valid;
    assign req.addr   = SAW'(acc_addr);
    assign req.wr     = acc_wr;
    assign req.wdata  = acc_din;
    assign req.wrmask = acc_mask;

    assign ok   = ok_q;
    assign dout = tag_data;

endmodule

/* sdram_mux/sdram_arbiter.sv */
// Fixed-priority SDRAM arbiter; maps each slot to its region and bank and runs the req/ack/rdy exchange
`include "game_mem_config.svh"

module sdram_arbiter (
    input  logic                    VB,
    input  logic                    rst_n,
    input  game_mem_pkg::slot_req_t reqs [`NUM_SLOTS],
    input  logic                    ram_sel,      // High for RAM, low for VRAM
    input  logic                    downloading,
    output logic [`NUM_SLOTS-1:0]   grant,
    output logic [`NUM_SLOTS-1:0]   done,
    output logic [31:0]             rdata,
    output logic                    sdram_req,
    output game_mem_pkg::sdram_cmd_t cmd,
    input  logic                    sdram_ack,
    input  logic                    data_rdy,
    input  logic [31:0]             data_read,
    output logic                    refresh_en
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e                 state;
    game_mem_pkg::slot_id_e sel;
    game_mem_pkg::slot_id_e cur;
    logic                   any_valid;
    logic                   start;
    logic [`SDRAM_AW-1:0]   offset;
    logic [1:0]             bank;

    // Lowest valid index wins
    always_comb begin
        any_valid = 1'b0;
        sel       = game_mem_pkg::SLOT_ROM;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (reqs[i].valid) begin
                any_valid = 1'b1;
                sel       = game_mem_pkg::slot_id_e'(i);
            end
        end
    end

    always_comb begin
        case (sel)
            game_mem_pkg::SLOT_ROM: begin
                offset = '0;
                bank   = `BANK_CPU;
            end
            game_mem_pkg::SLOT_RAM: begin
                offset = ram_sel ? `RAM_OFFSET : `VRAM_OFFSET;
                bank   = `BANK_CPU;
            end
            game_mem_pkg::SLOT_GFX: begin
                offset = '0;                        // Graphics own bank 2 from zero
                bank   = `BANK_GFX;
            end
            default: begin
                offset = '0;
                bank   = `BANK_SND;
            end
        endcase
    end

    assign start = (state == ST_IDLE) && any_valid && !downloading;

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            cur       <= game_mem_pkg::SLOT_ROM;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    state     <= ST_REQ;
                    sdram_req <= 1'b1;
                    cur       <= sel;
                end
                ST_REQ: if (sdram_ack) begin
                    state     <= ST_WAIT;
                    sdram_req <= 1'b0;
                end
                ST_WAIT: if (data_rdy)
                    state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command stays fixed from start until the next start
    always_ff @(posedge VB) begin
        if (start) begin
            cmd.addr   <= reqs[sel].addr + offset;
            cmd.bank   <= bank;
            cmd.rnw    <= !reqs[sel].wr;
            cmd.wdata  <= reqs[sel].wdata;
            cmd.wrmask <= reqs[sel].wrmask;
        end
    end

    // Grant goes out in the start cycle so the slot freezes its request
    always_comb begin
        grant = '0;
        done  = '0;
        if (state == ST_IDLE) begin
            if (start)
                grant[sel] = 1'b1;
        end else begin
            grant[cur] = 1'b1;
            if (state == ST_WAIT && data_rdy)
                done[cur] = 1'b1;
        end
    end

    assign rdata      = data_read;   // Valid together with done
    assign refresh_en = (state == ST_IDLE) && !any_valid;

endmodule

/* rom_load/rom_download.sv */
// Converts the byte-wide loader stream into SDRAM programming writes, held until the SDRAM acknowledges
`include "game_mem_config.svh"

module rom_download (
    input  logic                   VB,
    input  logic                   rst_n,
    input  logic                   downloading,
    input  logic [24:0]            ioctl_addr,
    input  logic [7:0]             ioctl_data,
    input  logic                   ioctl_wr,
    input  logic                   sdram_ack,
    output game_mem_pkg::prog_wr_t prog,
    output logic                   prog_we
);
    logic [24:0] base;
    logic [24:0] rel;
    logic [1:0]  bank;
    logic        take;

    // Region lookup from the stream position
    always_comb begin
        if (ioctl_addr < `SND_START) begin
            bank = `BANK_CPU;
            base = '0;
        end else if (ioctl_addr < `GFX_START) begin
            bank = `BANK_SND;
            base = `SND_START;
        end else begin
            bank = `BANK_GFX;
            base = `GFX_START;
        end
    end

    assign rel  = ioctl_addr - base;
    assign take = downloading && ioctl_wr && !prog_we;   // Bytes during a pending write are lost

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (prog_we) begin
            if (sdram_ack)
                prog_we <= 1'b0;
        end else if (take) begin
            prog_we <= 1'b1;
        end
    end

    always_ff @(posedge VB) begin
        if (take) begin
            prog.addr <= rel[`SDRAM_AW:1];
            prog.data <= ioctl_data;
            prog.mask <= rel[0] ? 2'b01 : 2'b10;
            prog.bank <= bank;
        end
    end

endmodule

/* design/game_mem_top.sv */
// Memory side top level: four requester slots, the SDRAM arbiter and the ROM download path
`include "game_mem_config.svh"

module game_mem_top (
    input  logic                     VB,
    input  logic                     rst_n,
    // ROM download
    input  logic                     downloading,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    output game_mem_pkg::prog_wr_t   prog,
    output logic                     prog_we,
    output logic                     dwnld_busy,
    // Main CPU ROM
    input  logic                     rom_cs,
    input  logic [`ROM_AW-1:0]       rom_addr,
    output logic                     rom_ok,
    output logic [15:0]              rom_dout,
    // Main CPU RAM and VRAM
    input  logic                     ram_cs,
    input  logic                     vram_cs,
    input  logic [`RAM_AW-1:0]       ram_addr,
    input  logic                     ram_wr,
    input  logic [15:0]              ram_din,
    input  logic [1:0]               ram_dsn,
    output logic                     ram_ok,
    output logic [15:0]              ram_dout,
    // Graphics ROM
    input  logic                     gfx_cs,
    input  logic [`GFX_AW-1:0]       gfx_addr,
    input  logic                     gfx_half,
    output logic                     gfx_ok,
    output logic [31:0]              gfx_dout,
    // Sound ROM
    input  logic                     snd_cs,
    input  logic [`SND_AW-1:0]       snd_addr,
    output logic                     snd_ok,
    output logic [7:0]               snd_dout,
    // SDRAM
    output logic                     sdram_req,
    output game_mem_pkg::sdram_cmd_t sdram_cmd,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    input  logic [31:0]              data_read,
    output logic                     refresh_en
);
    localparam int SAW = `SDRAM_AW;

    game_mem_pkg::slot_req_t rom_req, ram_req, gfx_req, snd_req;
    game_mem_pkg::slot_req_t reqs [`NUM_SLOTS];
    logic [`NUM_SLOTS-1:0]   grant;
    logic [`NUM_SLOTS-1:0]   done;
    logic [31:0]             rdata;
    logic [`RAM_AW:0]        ram_slot_addr;
    logic [`GFX_AW+1:0]      gfx_word;

    assign ram_slot_addr = {~ram_cs, ram_addr};         // Region bit keeps RAM and VRAM tags apart
    assign gfx_word      = {gfx_addr, gfx_half, 1'b0};  // 16-bit word address
    assign dwnld_busy    = downloading;

    always_comb begin
        reqs[game_mem_pkg::SLOT_ROM]      = rom_req;
        reqs[game_mem_pkg::SLOT_RAM]      = ram_req;
        reqs[game_mem_pkg::SLOT_RAM].addr = SAW'(ram_req.addr[`RAM_AW-1:0]);
        reqs[game_mem_pkg::SLOT_GFX]      = gfx_req;
        reqs[game_mem_pkg::SLOT_SND]      = snd_req;
        reqs[game_mem_pkg::SLOT_SND].addr = snd_req.addr >> 1;   // Byte to word
    end

    mem_slot #(.AW(`ROM_AW), .data_t(logic [15:0])) u_rom_slot (
        .VB(VB), .rst_n(rst_n), .cs(rom_cs), .addr(rom_addr),
        .wr(1'b0), .din(16'd0), .wrmask(2'b11), .req(rom_req),
        .grant(grant[game_mem_pkg::SLOT_ROM]), .done(done[game_mem_pkg::SLOT_ROM]),
        .rdata(rdata), .ok(rom_ok), .dout(rom_dout)
    );

    mem_slot #(.AW(`RAM_AW + 1), .data_t(logic [15:0])) u_ram_slot (
        .VB(VB), .rst_n(rst_n), .cs(ram_cs | vram_cs), .addr(ram_slot_addr),
        .wr(ram_wr), .din(ram_din), .wrmask(ram_dsn), .req(ram_req),
        .grant(grant[game_mem_pkg::SLOT_RAM]), .done(done[game_mem_pkg::SLOT_RAM]),
        .rdata(rdata), .ok(ram_ok), .dout(ram_dout)
    );

    mem_slot #(.AW(`GFX_AW + 2), .data_t(logic [31:0])) u_gfx_slot (
        .VB(VB), .rst_n(rst_n), .cs(gfx_cs), .addr(gfx_word),
        .wr(1'b0), .din(16'd0), .wrmask(2'b11), .req(gfx_req),
        .grant(grant[game_mem_pkg::SLOT_GFX]), .done(done[game_mem_pkg::SLOT_GFX]),
        .rdata(rdata), .ok(gfx_ok), .dout(gfx_dout)
    );

    mem_slot #(.AW(`SND_AW), .data_t(logic [7:0])) u_snd_slot (
        .VB(VB), .rst_n(rst_n), .cs(snd_cs), .addr(snd_addr),
        .wr(1'b0), .din(16'd0), .wrmask(2'b11), .req(snd_req),
        .grant(grant[game_mem_pkg::SLOT_SND]), .done(done[game_mem_pkg::SLOT_SND]),
        .rdata(rdata), .ok(snd_ok), .dout(snd_dout)
    );

    // Offset choice follows the latched request, not the live chip select
    sdram_arbiter u_arbiter (
        .VB(VB), .rst_n(rst_n), .reqs(reqs), .ram_sel(~ram_req.addr[`RAM_AW]),
        .downloading(downloading), .grant(grant), .done(done), .rdata(rdata),
        .sdram_req(sdram_req), .cmd(sdram_cmd), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .refresh_en(refresh_en)
    );

    rom_download u_download (
        .VB(VB), .rst_n(rst_n), .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr), .sdram_ack(sdram_ack),
        .prog(prog), .prog_we(prog_we)
    );

endmodule

/* tb/clk_gen.sv */
// Testbench clock and reset source: VB with a period of 100, rst_n held low for two cycles
module clk_gen (
    output logic VB,
    output logic rst_n
);
    initial begin
        VB = 1'b0;
        forever #50 VB = ~VB;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge VB);
        @(negedge VB) rst_n = 1'b1;   // Release away from the active edge
    end

endmodule

/* tb/sdram_model.sv */
// Behavioral SDRAM for the testbench: acks requests and programming writes, reads or stores words
`include "game_mem_config.svh"

module sdram_model (
    input  logic                     VB,
    input  logic                     rst_n,
    input  logic                     sdram_req,
    input  game_mem_pkg::sdram_cmd_t cmd,
    input  logic                     prog_we,
    output logic                     sdram_ack,
    output logic                     data_rdy,
    output logic [31:0]              data_read
);
    logic [31:0] mem [4096];
    integer      seed;
    logic [1:0]  st;
    logic [1:0]  cnt;
    logic        from_req;      // Programming writes are acked but not stored
    logic [11:0] key;

    initial begin
        seed = 5612;
        for (int i = 0; i < 4096; i++)
            mem[i] = $random(seed);
    end

    assign key = {cmd.bank, cmd.addr[21:20], cmd.addr[7:0]};

    always @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            st        <= 2'd0;
            cnt       <= 2'd0;
            from_req  <= 1'b0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            case (st)
                2'd0: if (sdram_req || prog_we) begin
                    st       <= 2'd1;
                    from_req <= sdram_req;
                end
                2'd1: begin
                    sdram_ack <= 1'b1;          // Two cycles after req
                    st        <= 2'd2;
                    cnt       <= 2'd0;
                end
                default: if (cnt == 2'd2) begin
                    data_rdy <= 1'b1;           // Three cycles after ack
                    st       <= 2'd0;
                    if (from_req && cmd.rnw)
                        data_read <= mem[key];
                    if (from_req && !cmd.rnw) begin
                        if (!cmd.wrmask[0])
                            mem[key][7:0] <= cmd.wdata[7:0];
                        if (!cmd.wrmask[1])
                            mem[key][15:8] <= cmd.wdata[15:8];
                    end
                end else begin
                    cnt <= cnt + 2'd1;
                end
            endcase
        end
    end

endmodule

/* tb/game_mem_asserts.sv */
// Strobe protocol checks bound into the arbiter and the download path
module game_mem_asserts (
    input logic VB,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic hold            // No new strobe may start while high
);
    // Request strobe holds until acknowledged
    assert property (@(posedge VB) disable iff (!rst_n) req && !ack |=> req)
        else $error("request strobe dropped before acknowledge");

    assert property (@(posedge VB) disable iff (!rst_n) hold && !req |=> !req)
        else $error("strobe started while held off");

endmodule

bind sdram_arbiter game_mem_asserts u_arb_chk (
    .VB(VB), .rst_n(rst_n), .req(sdram_req), .ack(sdram_ack), .hold(downloading)
);

bind rom_download game_mem_asserts u_dl_chk (
    .VB(VB), .rst_n(rst_n), .req(prog_we), .ack(sdram_ack), .hold(!downloading)
);

/* tb/game_mem_tb.sv */
// Simulation top that runs directed tests on the game memory top level
`include "game_mem_config.svh"

module game_mem_tb;
    localparam int TIMEOUT = 200;

    logic VB, rst_n;
    logic downloading, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0] ioctl_data;
    logic rom_cs, ram_cs, vram_cs, ram_wr, gfx_cs, gfx_half, snd_cs;
    logic [`ROM_AW-1:0] rom_addr;
    logic [`RAM_AW-1:0] ram_addr;
    logic [15:0] ram_din;
    logic [1:0] ram_dsn;
    logic [`GFX_AW-1:0] gfx_addr;
    logic [`SND_AW-1:0] snd_addr;
    logic rom_ok, ram_ok, gfx_ok, snd_ok;
    logic [15:0] rom_dout, ram_dout;
    logic [31:0] gfx_dout;
    logic [7:0] snd_dout;
    logic sdram_req, sdram_ack, data_rdy, refresh_en, prog_we, dwnld_busy;
    logic [31:0] data_read;
    game_mem_pkg::sdram_cmd_t sdram_cmd;
    game_mem_pkg::prog_wr_t prog;
    logic [31:0] shadow [4096];
    integer seed;

    clk_gen clk0 (.VB(VB), .rst_n(rst_n));

    sdram_model mdl0 (
        .VB(VB), .rst_n(rst_n), .sdram_req(sdram_req), .cmd(sdram_cmd), .prog_we(prog_we),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    game_mem_top dut0 (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("Error at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    // Model storage index from bank and word address
    function automatic int key_of(input logic [1:0] bank, input logic [21:0] addr);
        return {bank, addr[21:20], addr[7:0]};
    endfunction

    function automatic logic slot_ok(input int slot);
        case (slot)
            0: return rom_ok;
            1: return ram_ok;
            2: return gfx_ok;
            default: return snd_ok;
        endcase
    endfunction

    task automatic wait_slot(input int slot, input string what, output int cycles);
        cycles = 0;
        do begin
            @(negedge VB);
            cycles++;
            if (cycles > TIMEOUT)
                fail_run({"Timeout waiting for ", what, " ok"});
        end while (!slot_ok(slot));
    endtask

    // Waits for the next SDRAM request and checks its command
    task automatic expect_cmd(input logic [21:0] addr, input logic [1:0] bank, input logic rnw);
        int n;
        n = 0;
        while (sdram_req !== 1'b1) begin
            @(negedge VB);
            n++;
            if (n > TIMEOUT)
                fail_run("Timeout waiting for an SDRAM request");
        end
        compare("SDRAM command address", sdram_cmd.addr, addr);
        compare("SDRAM command bank", sdram_cmd.bank, bank);
        compare("SDRAM command read flag", sdram_cmd.rnw, rnw);
    endtask

    task automatic release_all;
        rom_cs = 1'b0;
        ram_cs = 1'b0;
        vram_cs = 1'b0;
        ram_wr = 1'b0;
        gfx_cs = 1'b0;
        snd_cs = 1'b0;
        @(negedge VB);
    endtask

    task automatic rom_read_test;
        int cyc;
        logic [21:0] a;
        a = 22'h1A5B3C;
        @(negedge VB);
        rom_addr = a[`ROM_AW-1:0];
        rom_cs = 1'b1;
        wait_slot(0, "ROM read", cyc);
        compare("ROM data", rom_dout, shadow[key_of(`BANK_CPU, a)][15:0]);
        release_all();
        rom_cs = 1'b1;                            // Same address again
        wait_slot(0, "ROM cached read", cyc);
        compare("ROM hit latency ok", cyc <= 2, 1);
        compare("ROM cached data", rom_dout, shadow[key_of(`BANK_CPU, a)][15:0]);
        release_all();
    endtask

    task automatic ram_access(input logic is_ram, input logic wr, input logic [15:0] data);
        int cyc;
        ram_cs = is_ram;
        vram_cs = !is_ram;
        ram_addr = 17'h0A5C3;
        ram_wr = wr;
        ram_din = data;
        ram_dsn = 2'b00;
        wait_slot(1, is_ram ? "RAM access" : "VRAM access", cyc);
    endtask

    task automatic ram_vram_test;
        logic [21:0] a;
        @(negedge VB);
        ram_access(1'b1, 1'b1, 16'hBEEF);
        release_all();
        ram_access(1'b0, 1'b1, 16'h1234);
        release_all();
        a = 22'h0A5C3 + `RAM_OFFSET;
        shadow[key_of(`BANK_CPU, a)][15:0] = 16'hBEEF;
        a = 22'h0A5C3 + `VRAM_OFFSET;
        shadow[key_of(`BANK_CPU, a)][15:0] = 16'h1234;
        ram_access(1'b1, 1'b0, 16'h0);
        compare("RAM readback", ram_dout, 16'hBEEF);
        release_all();
        ram_access(1'b0, 1'b0, 16'h0);
        compare("VRAM readback", ram_dout, 16'h1234);
        release_all();
    endtask

    task automatic gfx_snd_test;
        int cyc;
        logic [21:0] w;
        @(negedge VB);
        gfx_addr = 20'hAB5D2;
        gfx_half = 1'b1;
        gfx_cs = 1'b1;
        w = {20'hAB5D2, 1'b1, 1'b0};
        expect_cmd(w, `BANK_GFX, 1'b1);
        wait_slot(2, "graphics read", cyc);
        compare("graphics data", gfx_dout, shadow[key_of(`BANK_GFX, w)]);
        release_all();
        snd_addr = 16'h3A56;
        snd_cs = 1'b1;
        w = 22'h3A56 >> 1;
        wait_slot(3, "sound even read", cyc);
        compare("sound even byte", snd_dout, shadow[key_of(`BANK_SND, w)][7:0]);
        release_all();
        snd_addr = 16'h3A57;
        snd_cs = 1'b1;
        wait_slot(3, "sound odd read", cyc);
        compare("sound odd byte", snd_dout, shadow[key_of(`BANK_SND, w)][15:8]);
        release_all();
    endtask

    task automatic all_slots_test;
        int n;
        @(negedge VB);
        rom_addr = 21'h0F00A7;
        rom_cs = 1'b1;
        ram_addr = 17'h0A5C3;
        ram_wr = 1'b0;
        ram_cs = 1'b1;
        vram_cs = 1'b0;
        gfx_addr = 20'h12345;
        gfx_half = 1'b0;
        gfx_cs = 1'b1;
        snd_addr = 16'h7701;
        snd_cs = 1'b1;
        n = 0;
        while (!(rom_ok && ram_ok && gfx_ok && snd_ok)) begin
            @(negedge VB);
            n++;
            if (n > TIMEOUT)
                fail_run("Timeout waiting for all four slots to complete");
        end
        compare("parallel ROM", rom_dout, shadow[key_of(`BANK_CPU, 22'h0F00A7)][15:0]);
        compare("parallel RAM", ram_dout, 16'hBEEF);
        compare("parallel graphics", gfx_dout, shadow[key_of(`BANK_GFX, {20'h12345, 2'b00})]);
        compare("parallel sound", snd_dout, shadow[key_of(`BANK_SND, 22'h3B80)][15:8]);
        release_all();
    endtask

    task automatic download_byte(input logic [24:0] a, input logic [7:0] d);
        logic [24:0] base;
        logic [24:0] rel;
        logic [1:0] bank;
        int n;
        base = (a < `SND_START) ? 25'd0 : (a < `GFX_START) ? `SND_START : `GFX_START;
        bank = (a < `SND_START) ? 2'd1 : (a < `GFX_START) ? 2'd0 : 2'd2;
        rel = a - base;
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr = 1'b1;
        @(negedge VB);
        ioctl_wr = 1'b0;
        compare("prog_we after ioctl_wr", prog_we, 1);
        compare("prog address", prog.addr, rel[22:1]);
        compare("prog bank", prog.bank, bank);
        compare("prog mask", prog.mask, rel[0] ? 2'b01 : 2'b10);
        compare("prog data", prog.data, d);
        n = 0;
        while (prog_we) begin
            @(negedge VB);
            compare("sdram_req in download", sdram_req, 0);
            n++;
            if (n > TIMEOUT)
                fail_run("Timeout waiting for the programming write to be acknowledged");
        end
        @(negedge VB);
    endtask

    task automatic download_test;
        int cyc;
        logic [21:0] a;
        a = 22'h055A5A;
        @(negedge VB);
        downloading = 1'b1;
        @(negedge VB);
        compare("dwnld_busy high", dwnld_busy, 1);
        rom_addr = a[`ROM_AW-1:0];
        rom_cs = 1'b1;                            // Held off until the download ends
        download_byte(25'h000123, 8'h5A);
        download_byte(25'h07FFFE, 8'hC3);
        download_byte(25'h080010, 8'h11);
        download_byte(25'h0C0007, 8'hE4);
        download_byte(25'h0FFFFE, 8'h9D);
        compare("refresh_en with a slot waiting", refresh_en, 0);
        downloading = 1'b0;
        @(negedge VB);
        compare("dwnld_busy low", dwnld_busy, 0);
        wait_slot(0, "ROM read after download", cyc);
        compare("ROM data after download", rom_dout, shadow[key_of(`BANK_CPU, a)][15:0]);
        release_all();
    endtask

    initial begin
        int n;
        seed = 5612;
        for (int i = 0; i < 4096; i++)
            shadow[i] = $random(seed);        // Same sequence as the model preload
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        rom_cs = 1'b0;
        rom_addr = '0;
        ram_cs = 1'b0;
        vram_cs = 1'b0;
        ram_addr = '0;
        ram_wr = 1'b0;
        ram_din = '0;
        ram_dsn = 2'b11;
        gfx_cs = 1'b0;
        gfx_addr = '0;
        gfx_half = 1'b0;
        snd_cs = 1'b0;
        snd_addr = '0;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge VB);
            n++;
            if (n > TIMEOUT)
                fail_run("Timeout waiting for reset release");
        end
        @(negedge VB);
        compare("idle sdram_req", sdram_req, 0);
        compare("idle refresh_en", refresh_en, 1);
        compare("idle prog_we", prog_we, 0);
        rom_read_test();
        ram_vram_test();
        gfx_snd_test();
        all_slots_test();
        download_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/game_mem_pkg.sv
sdram_mux/mem_slot.sv
sdram_mux/sdram_arbiter.sv
rom_load/rom_download.sv
design/game_mem_top.sv
tb/clk_gen.sv
tb/sdram_model.sv
tb/game_mem_asserts.sv
tb/game_mem_tb.sv

/* Makefile */
TOP = game_mem_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir
